// ==== hw/sdram_cache_config.svh ====
`ifndef SDRAM_CACHE_CONFIG_SVH
`define SDRAM_CACHE_CONFIG_SVH

////////////////////
// Cache geometry
////////////////////

// Lines held in the cache
`define SDC_ENTRIES    4
// Bytes per line, one app burst of eight 16-bit words
`define SDC_LINE_BYTES 16
// CPU byte address width
`define SDC_ADDR_W     28
// Byte lanes returned by a big read
`define SDC_LANES      8

////////////////////
// App port commands
////////////////////

`define SDC_CMD_WRITE  3'b000
`define SDC_CMD_READ   3'b001

`endif

// ==== hw/sdram_cache_pkg.sv ====
`default_nettype none
`include "sdram_cache_config.svh"

package sdram_cache_pkg;

    typedef logic [`SDC_ADDR_W-1:0] byte_addr_t;                             // CPU byte address
    typedef logic [`SDC_ADDR_W-$clog2(`SDC_LINE_BYTES)-1:0] line_tag_t;     // Address minus offset
    typedef logic [`SDC_ADDR_W-1:0] app_addr_t;                              // App word address
    typedef logic [`SDC_LINE_BYTES*8-1:0] line_data_t;                       // One full line
    typedef logic [`SDC_LINE_BYTES-1:0] byte_mask_t;                         // Per-byte flags
    typedef logic [$clog2(`SDC_ENTRIES)-1:0] entry_idx_t;                    // Entry number
    typedef logic [`SDC_LANES-1:0] lane_mask_t;                              // Requested lanes
    typedef logic [`SDC_LANES*8-1:0] rd_data_t;                              // Lane 0 in bits 7:0
    typedef logic [15:0] half_t;                                             // CPU write data
    typedef logic [2:0] app_cmd_t;

    // Control states
    typedef enum logic [2:0] {
        START,      // Waiting for calibration
        IDLE,       // Ready for a request
        LOOKUP,     // Hit search
        VICTIM,     // Pick write-back or fill
        WRITE_BACK, // Issue victim write
        WB_WAIT,    // Victim write in flight
        FILL,       // Issue line read
        FILL_WAIT   // Line read in flight
    } cache_state_e;

endpackage

`default_nettype wire

// ==== hw/sdram_cache_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_fsm (
    input  wire  ui_clk,
    input  wire  arst_n,
    input  wire  calib_done,
    input  wire  sd_cs,
    input  wire  sd_we,
    input  wire  all_found,
    input  wire  victim_dirty,
    input  wire  rd_done,
    input  wire  wr_done,
    output logic sd_ready,
    output logic accept,
    output logic look_en,
    output logic commit_wr,
    output logic issue_rd,
    output logic issue_wr,
    output logic fill_en,
    output logic clean_en,
    output sdram_cache_pkg::cache_state_e state
);
    import sdram_cache_pkg::*;

    cache_state_e state_nxt;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_nxt = state; // Hold by default, covers back-pressure waits
        case (state)
            START: begin
                if (calib_done) state_nxt = IDLE;
            end
            IDLE: begin
                if (accept) state_nxt = LOOKUP;
            end
            LOOKUP: begin
                state_nxt = all_found ? IDLE : VICTIM;
            end
            VICTIM: begin
                // Dirty victim goes out before the fill
                state_nxt = victim_dirty ? WRITE_BACK : FILL;
            end
            WRITE_BACK: begin
                state_nxt = WB_WAIT;
            end
            WB_WAIT: begin
                if (wr_done) state_nxt = FILL;
            end
            FILL: begin
                state_nxt = FILL_WAIT;
            end
            FILL_WAIT: begin
                if (rd_done) state_nxt = LOOKUP; // Retry, a big read may miss again
            end
            default: begin
                state_nxt = START;
            end
        endcase
    end

    ////////////////////
    // State and ready
    ////////////////////

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= START;
            sd_ready <= 1'b0;
        end else begin
            state    <= state_nxt;
            // Rises one edge after entering IDLE, drops on accept
            sd_ready <= (state == IDLE) && !accept;
        end
    end

    // Strobes to the datapath
    assign accept    = (state == IDLE) && sd_ready && sd_cs;
    assign look_en   = (state == LOOKUP);               // Register read result
    assign commit_wr = look_en && all_found && sd_we;   // Hit write, all lanes present
    assign issue_wr  = (state == WRITE_BACK);
    assign issue_rd  = (state == FILL);
    assign clean_en  = (state == WB_WAIT) && wr_done;   // Victim now matches SDRAM
    assign fill_en   = (state == FILL_WAIT) && rd_done; // Load the new line

endmodule

`default_nettype wire

// ==== hw/sdram_cache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sdram_cache_config.svh"

module sdram_cache_lookup (
    input  wire                                            ui_clk,
    input  wire                                            arst_n,
    input  wire                                            accept,
    input  wire                                            look_en,
    input  wire  sdram_cache_pkg::byte_addr_t              sd_addr,
    input  wire                                            sd_l,
    input  wire                                            sd_u,
    input  wire                                            sd_we,
    input  wire                                            sd_big_r,
    input  wire  sdram_cache_pkg::half_t                   sd_wr,
    input  wire  [`SDC_ENTRIES-1:0]                        line_valid,
    input  wire  sdram_cache_pkg::line_tag_t [`SDC_ENTRIES-1:0]  line_tags,
    input  wire  sdram_cache_pkg::line_data_t [`SDC_ENTRIES-1:0] line_data,
    output logic                                           all_found,
    output logic                                           req_we,
    output sdram_cache_pkg::byte_addr_t                    req_addr,
    output sdram_cache_pkg::lane_mask_t                    req_lanes,
    output sdram_cache_pkg::half_t                         req_wr,
    output sdram_cache_pkg::line_tag_t                     miss_tag,
    output sdram_cache_pkg::rd_data_t                      rd_data
);
    import sdram_cache_pkg::*;

    byte_addr_t                            lane_addr [`SDC_LANES]; // Byte address per lane
    line_tag_t                             lane_tag  [`SDC_LANES];
    logic [$clog2(`SDC_LINE_BYTES)-1:0]    lane_off  [`SDC_LANES]; // Byte within line
    lane_mask_t                            found;
    rd_data_t                              lane_bytes;

    ////////////////////
    // Request capture
    ////////////////////

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            req_we    <= 1'b0;
            req_lanes <= '0;
        end else if (accept) begin
            req_we    <= sd_we;
            // Big read flag taken here, lanes 2..7 only on reads
            req_lanes <= {{(`SDC_LANES-2){sd_big_r && !sd_we}}, sd_u, sd_l};
        end
    end

    always_ff @(posedge ui_clk) begin
        if (accept) begin
            req_addr <= sd_addr;
            req_wr   <= sd_wr;
        end
    end

    ////////////////////
    // Hit search
    ////////////////////

    always_comb begin
        found      = '0; // Fresh on every lookup
        lane_bytes = '0; // Unselected lanes read zero
        for (int i = 0; i < `SDC_LANES; i++) begin
            lane_addr[i] = req_addr + byte_addr_t'(i); // May cross into the next line
            lane_tag[i]  = line_tag_t'(lane_addr[i] >> $clog2(`SDC_LINE_BYTES));
            lane_off[i]  = lane_addr[i][$clog2(`SDC_LINE_BYTES)-1:0];
            for (int e = 0; e < `SDC_ENTRIES; e++) begin
                if (req_lanes[i] && line_valid[e] && line_tags[e] == lane_tag[i]) begin
                    found[i]            = 1'b1;
                    lane_bytes[i*8 +: 8] = line_data[e][{lane_off[i], 3'b000} +: 8];
                end
            end
        end
        // Lowest missing lane wins
        miss_tag = lane_tag[0];
        for (int i = `SDC_LANES-1; i >= 0; i--) begin
            if (req_lanes[i] && !found[i]) miss_tag = lane_tag[i];
        end
    end

    assign all_found = (found == req_lanes);

    // Read result, held while sd_ready is high
    always_ff @(posedge ui_clk) begin
        if (look_en) rd_data <= lane_bytes;
    end

endmodule

`default_nettype wire

// ==== hw/sdram_cache_lines.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sdram_cache_config.svh"

module sdram_cache_lines (
    input  wire                                            ui_clk,
    input  wire                                            arst_n,
    input  wire                                            fill_en,
    input  wire                                            commit_wr,
    input  wire                                            clean_en,
    input  wire  sdram_cache_pkg::line_tag_t               fill_tag,
    input  wire  sdram_cache_pkg::line_data_t              fill_data,
    input  wire  sdram_cache_pkg::byte_addr_t              req_addr,
    input  wire  sdram_cache_pkg::lane_mask_t              req_lanes,
    input  wire  sdram_cache_pkg::half_t                   req_wr,
    output logic [`SDC_ENTRIES-1:0]                        line_valid,
    output sdram_cache_pkg::line_tag_t [`SDC_ENTRIES-1:0]  line_tags,
    output sdram_cache_pkg::line_data_t [`SDC_ENTRIES-1:0] line_data,
    output logic                                           victim_dirty,
    output sdram_cache_pkg::line_tag_t                     victim_tag,
    output sdram_cache_pkg::line_data_t                    victim_data
);
    import sdram_cache_pkg::*;

    byte_mask_t                            dirty [`SDC_ENTRIES]; // Bytes changed since fill
    entry_idx_t                            victim_ptr;           // FIFO replacement
    byte_addr_t                            wr_addr [2];
    logic [$clog2(`SDC_LINE_BYTES)-1:0]    wr_off  [2];
    logic [`SDC_ENTRIES-1:0]               wr_hit  [2];          // Entry holding each lane

    ////////////////////
    // Write lane match
    ////////////////////

    // Lanes 0 and 1 may sit in different entries
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_addr[i] = req_addr + byte_addr_t'(i);
            wr_off[i]  = wr_addr[i][$clog2(`SDC_LINE_BYTES)-1:0];
            for (int e = 0; e < `SDC_ENTRIES; e++) begin
                wr_hit[i][e] = req_lanes[i] && line_valid[e] &&
                               line_tags[e] == line_tag_t'(wr_addr[i] >> $clog2(`SDC_LINE_BYTES));
            end
        end
    end

    ////////////////////
    // Valid, dirty, pointer
    ////////////////////

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
            victim_ptr <= '0;
            for (int e = 0; e < `SDC_ENTRIES; e++) begin
                dirty[e] <= '0;
            end
        end else begin
            if (fill_en) begin
                line_valid[victim_ptr] <= 1'b1;
                dirty[victim_ptr]      <= '0;             // Fresh from SDRAM
                victim_ptr             <= victim_ptr + 1'b1; // Oldest entry next
            end
            if (clean_en) dirty[victim_ptr] <= '0;        // Written back
            if (commit_wr) begin
                for (int i = 0; i < 2; i++) begin
                    for (int e = 0; e < `SDC_ENTRIES; e++) begin
                        if (wr_hit[i][e]) dirty[e][wr_off[i]] <= 1'b1;
                    end
                end
            end
        end
    end

    // Tags and data
    always_ff @(posedge ui_clk) begin
        if (fill_en) begin
            line_tags[victim_ptr] <= fill_tag;
            line_data[victim_ptr] <= fill_data;
        end
        if (commit_wr) begin
            for (int i = 0; i < 2; i++) begin
                for (int e = 0; e < `SDC_ENTRIES; e++) begin
                    if (wr_hit[i][e]) line_data[e][{wr_off[i], 3'b000} +: 8] <= req_wr[i*8 +: 8];
                end
            end
        end
    end

    // Victim view for write-back
    assign victim_dirty = line_valid[victim_ptr] && (dirty[victim_ptr] != '0);
    assign victim_tag   = line_tags[victim_ptr];
    assign victim_data  = line_data[victim_ptr];

endmodule

`default_nettype wire

// ==== hw/sdram_cache_app_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sdram_cache_config.svh"

module sdram_cache_app_port (
    input  wire                               ui_clk,
    input  wire                               arst_n,
    input  wire                               issue_rd,
    input  wire                               issue_wr,
    input  wire  sdram_cache_pkg::line_tag_t  miss_tag,
    input  wire  sdram_cache_pkg::line_tag_t  victim_tag,
    input  wire  sdram_cache_pkg::line_data_t victim_data,
    input  wire                               app_rdy,
    input  wire                               app_wdf_rdy,
    input  wire                               app_rd_data_valid,
    input  wire  sdram_cache_pkg::line_data_t app_rd_data,
    output sdram_cache_pkg::app_addr_t        app_addr,
    output sdram_cache_pkg::app_cmd_t         app_cmd,
    output logic                              app_en,
    output logic                              app_wdf_wren,
    output sdram_cache_pkg::line_data_t       app_wdf_data,
    output logic                              rd_done,
    output logic                              wr_done,
    output sdram_cache_pkg::line_tag_t        fill_tag,
    output sdram_cache_pkg::line_data_t       fill_data
);
    import sdram_cache_pkg::*;

    logic wr_pend; // Write issued, not yet fully taken

    // Port counts 16-bit words, a line is a burst of eight
    function automatic app_addr_t line_addr(input line_tag_t tag);
        return app_addr_t'({tag, 3'b000});
    endfunction

    ////////////////////
    // Handshake flags
    ////////////////////

    always_ff @(posedge ui_clk or negedge arst_n) begin
        if (!arst_n) begin
            app_en       <= 1'b0;
            app_wdf_wren <= 1'b0;
            wr_pend      <= 1'b0;
            rd_done      <= 1'b0;
        end else begin
            rd_done <= app_rd_data_valid; // One cycle, data captured alongside
            if (issue_rd || issue_wr) app_en <= 1'b1;
            else if (app_rdy)         app_en <= 1'b0; // Command taken
            if (issue_wr)             app_wdf_wren <= 1'b1;
            else if (app_wdf_rdy)     app_wdf_wren <= 1'b0; // Data taken
            if (issue_wr)             wr_pend <= 1'b1;
            else if (wr_done)         wr_pend <= 1'b0;
        end
    end

    // Both halves of the write accepted
    assign wr_done = wr_pend && !app_en && !app_wdf_wren;

    ////////////////////
    // Command and data
    ////////////////////

    always_ff @(posedge ui_clk) begin
        if (issue_rd) begin
            app_cmd  <= `SDC_CMD_READ;
            app_addr <= line_addr(miss_tag);
            fill_tag <= miss_tag; // Line being fetched
        end
        if (issue_wr) begin
            app_cmd      <= `SDC_CMD_WRITE;
            app_addr     <= line_addr(victim_tag);
            app_wdf_data <= victim_data; // Whole line goes back
        end
        if (app_rd_data_valid) fill_data <= app_rd_data;
    end

endmodule

`default_nettype wire

// ==== hw/sdram_cache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sdram_cache_config.svh"

module sdram_cache (
    input  wire                               ui_clk,
    input  wire                               arst_n,
    input  wire                               calib_done,
    // CPU request port
    input  wire  sdram_cache_pkg::byte_addr_t sd_addr,
    input  wire                               sd_cs,
    input  wire                               sd_l,
    input  wire                               sd_u,
    input  wire                               sd_we,
    input  wire  sdram_cache_pkg::half_t      sd_wr,
    input  wire                               sd_big_r,
    output wire  [15:0]                       sd_rd,    // Lanes 0 and 1
    output wire  [47:0]                       sd_rd48,  // Lanes 2 to 7
    output wire                               sd_ready,
    // DDR3 controller app port
    output wire  sdram_cache_pkg::app_addr_t  app_addr,
    output wire  sdram_cache_pkg::app_cmd_t   app_cmd,
    output wire                               app_en,
    output wire  sdram_cache_pkg::line_data_t app_wdf_data,
    output wire                               app_wdf_wren,
    input  wire                               app_rdy,
    input  wire                               app_wdf_rdy,
    input  wire  sdram_cache_pkg::line_data_t app_rd_data,
    input  wire                               app_rd_data_valid
);
    import sdram_cache_pkg::*;

    // FSM strobes
    logic accept;
    logic look_en;
    logic commit_wr;
    logic issue_rd;
    logic issue_wr;
    logic fill_en;
    logic clean_en;
    cache_state_e state;

    // Held request and search result
    logic       all_found;
    logic       req_we;
    byte_addr_t req_addr;
    lane_mask_t req_lanes;
    half_t      req_wr;
    line_tag_t  miss_tag;

    // Line store
    logic [`SDC_ENTRIES-1:0]       line_valid;
    line_tag_t [`SDC_ENTRIES-1:0]  line_tags;
    line_data_t [`SDC_ENTRIES-1:0] line_data;
    logic                          victim_dirty;
    line_tag_t                     victim_tag;
    line_data_t                    victim_data;

    // Fill and write-back completion
    logic       rd_done;
    logic       wr_done;
    line_tag_t  fill_tag;
    line_data_t fill_data;

    sdram_cache_fsm u_fsm (
        .sd_we (req_we), // Write flag of the held request
        .*
    );

    sdram_cache_lookup u_lookup (
        .rd_data ({sd_rd48, sd_rd}),
        .*
    );

    sdram_cache_lines u_lines (.*);

    sdram_cache_app_port u_app_port (.*);

endmodule

`default_nettype wire

// ==== sim/sdram_cache_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_props (
    input  wire                                ui_clk,
    input  wire                                arst_n,
    input  wire                                calib_done,
    input  wire                                sd_ready,
    input  wire                                accept,
    input  wire                                all_found,
    input  wire sdram_cache_pkg::cache_state_e state,
    input  wire                                app_en,
    input  wire                                app_rdy,
    input  wire sdram_cache_pkg::app_addr_t    app_addr,
    input  wire sdram_cache_pkg::app_cmd_t     app_cmd,
    input  wire                                app_wdf_wren,
    input  wire                                app_wdf_rdy,
    input  wire sdram_cache_pkg::line_data_t   app_wdf_data
);
    import sdram_cache_pkg::*;

    int fail_count = 0; // Failed protocol checks

    ////////////////////
    // Reset and calibration
    ////////////////////

    // First edge out of reset, everything quiet
    reset_quiet: assert property (@(posedge ui_clk) $rose(arst_n) |->
        !sd_ready && !app_en && !app_wdf_wren && state == START)
        else begin fail_count++; $error("outputs not idle after reset"); end

    calib_gate: assert property (@(posedge ui_clk) disable iff (!arst_n)
        !calib_done |-> !sd_ready)
        else begin fail_count++; $error("sd_ready high before calibration"); end

    ////////////////////
    // Handshakes
    ////////////////////

    ready_drop: assert property (@(posedge ui_clk) disable iff (!arst_n)
        accept |=> !sd_ready)
        else begin fail_count++; $error("sd_ready still high after accept"); end

    // Command held until the controller takes it
    cmd_hold: assert property (@(posedge ui_clk) disable iff (!arst_n)
        app_en && !app_rdy |=> app_en && $stable(app_addr) && $stable(app_cmd))
        else begin fail_count++; $error("app command changed under back-pressure"); end

    data_hold: assert property (@(posedge ui_clk) disable iff (!arst_n)
        app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data))
        else begin fail_count++; $error("write data changed under back-pressure"); end

    // Hit: ready back two edges after accept, no SDRAM traffic
    hit_timing: assert property (@(posedge ui_clk) disable iff (!arst_n)
        accept ##1 (state == LOOKUP && all_found) |=>
        (!sd_ready && !app_en) ##1 (sd_ready && !app_en))
        else begin fail_count++; $error("hit did not complete in two edges"); end

endmodule

`default_nettype wire

// ==== sim/sdram_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sdram_cache_config.svh"

module sdram_cache_tb;
    import sdram_cache_pkg::*;

    localparam int DIRECTED   = 21;                          // Fixed requests below
    localparam int N_RANDOM   = 40;
    localparam int MAX_CYCLES = (DIRECTED + N_RANDOM) * 200; // Per-request budget

    logic        ui_clk;
    logic        arst_n;
    logic        calib_done;
    byte_addr_t  sd_addr;
    logic        sd_cs;
    logic        sd_l;
    logic        sd_u;
    logic        sd_we;
    half_t       sd_wr;
    logic        sd_big_r;
    logic [15:0] sd_rd;
    logic [47:0] sd_rd48;
    logic        sd_ready;
    app_addr_t   app_addr;
    app_cmd_t    app_cmd;
    logic        app_en;
    line_data_t  app_wdf_data;
    logic        app_wdf_wren;
    logic        app_rdy;
    logic        app_wdf_rdy;
    line_data_t  app_rd_data;
    logic        app_rd_data_valid;

    logic [31:0] stim_lfsr;              // Request stream
    logic [31:0] model_lfsr;             // Stalls and read delay
    logic [7:0]  shadow [byte_addr_t];   // Expected contents
    logic [7:0]  sdram  [byte_addr_t];   // Sparse SDRAM
    bit          wb_seen [byte_addr_t];  // Lines written back
    int          data_errors;
    int          cycles;
    logic        rd_busy;
    int          rd_count;
    byte_addr_t  rd_base;
    byte_addr_t  wr_base;
    logic        cmd_taken;
    logic        data_taken;
    line_data_t  wr_line;

    sdram_cache uut (.*);

    bind sdram_cache sdram_cache_props u_props (.*);

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk; // 4 ns period
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit(inout logic [31:0] s);
        logic b;
        b = s[0];
        s = s >> 1;
        if (b) s = s ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] random_bits(inout logic [31:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit(s)};
        end
        return v;
    endfunction

    // Unwritten bytes, folded address
    function automatic logic [7:0] pattern_byte(input byte_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {4'h0, a[27:24]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] shadow_byte(input byte_addr_t a);
        return shadow.exists(a) ? shadow[a] : pattern_byte(a);
    endfunction

    function automatic logic [7:0] sdram_byte(input byte_addr_t a);
        return sdram.exists(a) ? sdram[a] : pattern_byte(a);
    endfunction

    function automatic line_data_t load_line(input byte_addr_t base);
        line_data_t d;
        for (int k = 0; k < `SDC_LINE_BYTES; k++) begin
            d[k*8 +: 8] = sdram_byte(base + byte_addr_t'(k));
        end
        return d;
    endfunction

    // Whole line must match what the CPU has written so far
    task automatic store_line(input byte_addr_t base, input line_data_t data);
        byte_addr_t a;
        for (int k = 0; k < `SDC_LINE_BYTES; k++) begin
            a = base + byte_addr_t'(k);
            assert (data[k*8 +: 8] == shadow_byte(a)) else begin
                data_errors++;
                $display("mismatch write-back @%h: expected %h, actual %h",
                         a, shadow_byte(a), data[k*8 +: 8]);
            end
            sdram[a] = data[k*8 +: 8];
        end
        wb_seen[base] = 1'b1;
    endtask

    ////////////////////
    // SDRAM model
    ////////////////////

    always @(posedge ui_clk) begin
        if (app_en && app_rdy) begin
            if (app_cmd == `SDC_CMD_READ) begin
                rd_base  = byte_addr_t'({app_addr, 1'b0});          // Word to byte address
                rd_count = 2 + int'(random_bits(model_lfsr, 3));   // Data 3 to 10 edges later
                rd_busy  = 1'b1;
            end else begin
                wr_base   = byte_addr_t'({app_addr, 1'b0});
                cmd_taken = 1'b1;
            end
        end
        if (app_wdf_wren && app_wdf_rdy) begin
            wr_line    = app_wdf_data;
            data_taken = 1'b1;
        end
        if (cmd_taken && data_taken) begin // Command and data may land on different edges
            store_line(wr_base, wr_line);
            cmd_taken  = 1'b0;
            data_taken = 1'b0;
        end
        app_rd_data_valid <= 1'b0;
        if (rd_busy) begin
            if (rd_count == 0) begin
                app_rd_data       <= load_line(rd_base);
                app_rd_data_valid <= 1'b1; // Single pulse
                rd_busy            = 1'b0;
            end else begin
                rd_count--;
            end
        end
        app_rdy     <= lfsr_bit(model_lfsr) | lfsr_bit(model_lfsr); // Ready 3 of 4 edges
        app_wdf_rdy <= lfsr_bit(model_lfsr) | lfsr_bit(model_lfsr);
    end

    ////////////////////
    // Requests
    ////////////////////

    task automatic request(input string name, input byte_addr_t addr, input logic we,
                           input logic l, input logic u, input logic big, input half_t wr);
        logic [63:0] expected;
        logic        sel;
        @(negedge ui_clk);
        while (!sd_ready) @(negedge ui_clk);
        @(posedge ui_clk);
        sd_addr  <= addr;
        sd_we    <= we;
        sd_l     <= l;
        sd_u     <= u;
        sd_big_r <= big;
        sd_wr    <= wr;
        sd_cs    <= 1'b1;
        @(posedge ui_clk);
        sd_cs <= 1'b0; // Accepted on this edge
        @(negedge ui_clk);
        while (!sd_ready) @(negedge ui_clk);
        if (we) begin
            if (l) shadow[addr] = wr[7:0];
            if (u) shadow[addr + 1] = wr[15:8];
        end else begin
            expected = '0;
            for (int k = 0; k < `SDC_LANES; k++) begin
                sel = (k == 0) ? l : (k == 1) ? u : big;
                if (sel) expected[k*8 +: 8] = shadow_byte(addr + byte_addr_t'(k));
            end
            assert (sd_rd == expected[15:0]) else begin
                data_errors++;
                $display("mismatch %s @%h sd_rd: expected %h, actual %h",
                         name, addr, expected[15:0], sd_rd);
            end
            assert (sd_rd48 == expected[63:16]) else begin
                data_errors++;
                $display("mismatch %s @%h sd_rd48: expected %h, actual %h",
                         name, addr, expected[63:16], sd_rd48);
            end
        end
    endtask

    initial begin
        byte_addr_t ra;
        logic [3:0] rflags;
        half_t      rwr;
        arst_n            = 1'b0;
        calib_done        = 1'b0;
        sd_addr           = '0;
        sd_cs             = 1'b0;
        sd_l              = 1'b0;
        sd_u              = 1'b0;
        sd_we             = 1'b0;
        sd_wr             = '0;
        sd_big_r          = 1'b0;
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
        stim_lfsr         = 32'h26ba;
        model_lfsr        = 32'h26ba;
        data_errors       = 0;
        rd_busy           = 1'b0;
        rd_count          = 0;
        cmd_taken         = 1'b0;
        data_taken        = 1'b0;
        repeat (4) @(posedge ui_clk);
        arst_n <= 1'b1;
        repeat (10) @(posedge ui_clk);
        calib_done <= 1'b1;

        // Byte lanes, then read back
        request("write byte", 28'h100, 1'b1, 1'b1, 1'b0, 1'b0, 16'h00a1);
        request("write half", 28'h104, 1'b1, 1'b1, 1'b1, 1'b0, 16'hb2c3);
        request("write upper", 28'h10a, 1'b1, 1'b0, 1'b1, 1'b0, 16'hd400);
        request("read byte", 28'h100, 1'b0, 1'b1, 1'b1, 1'b0, '0);  // Upper never written
        request("read half", 28'h104, 1'b0, 1'b1, 1'b1, 1'b0, '0);
        request("read upper", 28'h10a, 1'b0, 1'b0, 1'b1, 1'b0, '0); // Lane 0 reads zero
        request("read fresh", 28'h110, 1'b0, 1'b1, 1'b0, 1'b0, '0);

        // Big reads, offsets 9 and up cross a line
        request("big read", 28'h100, 1'b0, 1'b1, 1'b1, 1'b1, '0);
        for (int off = 9; off < 16; off++) begin
            request("big read cross", 28'h200 + off, 1'b0, 1'b1, 1'b1, 1'b1, '0);
        end

        // Dirty one line, four fills push it out
        request("dirty line", 28'h3005, 1'b1, 1'b1, 1'b0, 1'b0, 16'h00c3);
        for (int n = 4; n < 8; n++) begin
            request("evict fill", byte_addr_t'(n) << 12, 1'b0, 1'b1, 1'b0, 1'b0, '0);
        end
        assert (wb_seen.exists(28'h3000)) else begin
            data_errors++;
            $display("eviction: dirty line at 3000 was never written back");
        end
        request("read evicted", 28'h3005, 1'b0, 1'b1, 1'b1, 1'b0, '0);

        // Random mix over 16 lines, heavy eviction
        for (int i = 0; i < N_RANDOM; i++) begin
            ra     = byte_addr_t'(random_bits(stim_lfsr, 8));
            rflags = random_bits(stim_lfsr, 4); // we, l, u, big
            rwr    = random_bits(stim_lfsr, 16);
            request("random", ra, rflags[3], rflags[2], rflags[1], rflags[0], rwr);
        end

        repeat (4) @(posedge ui_clk);
        $display("errors: data %0d, protocol %0d", data_errors, uut.u_props.fail_count);
        if (data_errors == 0 && uut.u_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge ui_clk);
            cycles++;
        end
        $display("timeout: run not finished after %0d cycles, data errors %0d",
                 cycles, data_errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sdram_cache.f ====
+incdir+hw
hw/sdram_cache_pkg.sv
hw/sdram_cache_fsm.sv
hw/sdram_cache_lookup.sv
hw/sdram_cache_lines.sv
hw/sdram_cache_app_port.sv
hw/sdram_cache.sv
sim/sdram_cache_props.sv
sim/sdram_cache_tb.sv

// ==== Bender.yml ====
package:
  name: sdram_cache

sources:
  - include_dirs:
      - hw
    files:
      - hw/sdram_cache_pkg.sv
      - hw/sdram_cache_fsm.sv
      - hw/sdram_cache_lookup.sv
      - hw/sdram_cache_lines.sv
      - hw/sdram_cache_app_port.sv
      - hw/sdram_cache.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/sdram_cache_props.sv
      - sim/sdram_cache_tb.sv
